// File: hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int num_aregs   = 16;
    localparam int num_pregs   = 32;
    localparam int queue_depth = 4;  // Input credits handed to decode
    localparam int rob_credits = 8;

    // Pointer widths carry one wrap bit
    localparam int qptr_w     = $clog2(queue_depth) + 1;
    localparam int flptr_w    = $clog2(num_pregs) + 1;
    localparam int rob_cnt_w  = $clog2(rob_credits + 1);

    typedef logic [$clog2(num_aregs)-1:0]   areg_t;
    typedef logic [$clog2(num_pregs)-1:0]   preg_t;
    typedef logic [31:0]                    data_t;
    typedef logic [$clog2(rob_credits)-1:0] rob_id_t;

    // Only op_reg operands go through the alias table
    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_reg  = 2'd1,
        op_imm  = 2'd2
    } opkind_e;

    typedef enum logic [1:0] {
        st_init    = 2'd0,
        st_run     = 2'd1,
        st_recover = 2'd2
    } rn_state_e;

endpackage

`default_nettype wire

// File: hw/uop_queue.sv
`default_nettype none

module uop_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  rename_pkg::opkind_e dst_kind,
    input  rename_pkg::areg_t  dst_areg,
    input  rename_pkg::opkind_e src1_kind,
    input  rename_pkg::areg_t  src1_areg,
    input  rename_pkg::opkind_e src2_kind,
    input  rename_pkg::areg_t  src2_areg,
    input  logic               pop,
    input  logic               nuke,
    output logic               empty,
    output rename_pkg::opkind_e head_dst_kind,
    output rename_pkg::areg_t  head_dst_areg,
    output rename_pkg::opkind_e head_src1_kind,
    output rename_pkg::areg_t  head_src1_areg,
    output rename_pkg::opkind_e head_src2_kind,
    output rename_pkg::areg_t  head_src2_areg
);
    import rename_pkg::*;

    opkind_e dst_kind_q [queue_depth];
    areg_t   dst_areg_q [queue_depth];
    opkind_e src1_kind_q [queue_depth];
    areg_t   src1_areg_q [queue_depth];
    opkind_e src2_kind_q [queue_depth];
    areg_t   src2_areg_q [queue_depth];

    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;

    // Decode credits keep the queue from overflowing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (nuke) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !nuke) begin
            dst_kind_q[wr_ptr[qptr_w-2:0]]  <= dst_kind;
            dst_areg_q[wr_ptr[qptr_w-2:0]]  <= dst_areg;
            src1_kind_q[wr_ptr[qptr_w-2:0]] <= src1_kind;
            src1_areg_q[wr_ptr[qptr_w-2:0]] <= src1_areg;
            src2_kind_q[wr_ptr[qptr_w-2:0]] <= src2_kind;
            src2_areg_q[wr_ptr[qptr_w-2:0]] <= src2_areg;
        end
    end

    assign empty          = (wr_ptr == rd_ptr);
    assign head_dst_kind  = dst_kind_q[rd_ptr[qptr_w-2:0]];
    assign head_dst_areg  = dst_areg_q[rd_ptr[qptr_w-2:0]];
    assign head_src1_kind = src1_kind_q[rd_ptr[qptr_w-2:0]];
    assign head_src1_areg = src1_areg_q[rd_ptr[qptr_w-2:0]];
    assign head_src2_kind = src2_kind_q[rd_ptr[qptr_w-2:0]];
    assign head_src2_areg = src2_areg_q[rd_ptr[qptr_w-2:0]];

endmodule

`default_nettype wire

// File: hw/rename_credit.sv
`default_nettype none

module rename_credit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                spend,
    input  logic                credit_ret,
    input  logic                nuke,
    output logic                has_credit,
    output rename_pkg::rob_id_t robid
);
    import rename_pkg::*;

    logic [rob_cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= rob_cnt_w'(rob_credits);
            robid <= '0;
        end else if (nuke) begin
            cnt   <= rob_cnt_w'(rob_credits);
            robid <= '0;
        end else begin
            // Spend and return in one cycle cancel out
            if (spend && !credit_ret && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (credit_ret && !spend && cnt != rob_cnt_w'(rob_credits)) begin
                cnt <= cnt + 1'b1;
            end
            if (spend) robid <= robid + 1'b1;  // Wraps with the id width
        end
    end

    assign has_credit = (cnt != '0);

endmodule

`default_nettype wire

// File: hw/rename_ctrl.sv
`default_nettype none

module rename_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  nuke,
    output rename_pkg::rn_state_e state,
    output rename_pkg::preg_t     scan_idx,
    output logic                  scan_en
);
    import rename_pkg::*;

    rn_state_e state_nxt;
    preg_t     idx_nxt;
    logic      scan_last;

    assign scan_last = (scan_idx == preg_t'(num_pregs - 1));

    always_comb begin
        state_nxt = state;
        idx_nxt   = scan_idx;
        if (nuke) begin
            // Restart the scan even if one is already running
            state_nxt = st_recover;
            idx_nxt   = '0;
        end else begin
            case (state)
                st_init, st_recover: begin
                    if (scan_last) begin
                        state_nxt = st_run;
                        idx_nxt   = '0;
                    end else begin
                        idx_nxt = scan_idx + 1'b1;
                    end
                end
                default: begin
                    state_nxt = st_run;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_init;
            scan_idx <= '0;
        end else begin
            state    <= state_nxt;
            scan_idx <= idx_nxt;
        end
    end

    assign scan_en = (state != st_run);

endmodule

`default_nettype wire

// File: hw/rename_map.sv
`default_nettype none

module rename_map (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ren_en,
    input  logic              ren_dst_en,
    input  rename_pkg::areg_t dst_areg,
    input  rename_pkg::areg_t src1_areg,
    input  rename_pkg::areg_t src2_areg,
    input  rename_pkg::preg_t new_preg,
    input  logic              commit_valid,
    input  rename_pkg::areg_t commit_areg,
    input  rename_pkg::preg_t commit_preg,
    input  logic              restore,
    output rename_pkg::preg_t psrc1,
    output rename_pkg::preg_t psrc2,
    output rename_pkg::preg_t pdst_old,
    output rename_pkg::preg_t commit_old,
    output logic [rename_pkg::num_pregs-1:0] used_vec
);
    import rename_pkg::*;

    preg_t spec_map [num_aregs];
    preg_t cmt_map  [num_aregs];
    preg_t cmt_nxt  [num_aregs];

    // Committed table as it stands after this cycle's commit
    always_comb begin
        for (int i = 0; i < num_aregs; i++) begin
            cmt_nxt[i] = cmt_map[i];
        end
        if (commit_valid) cmt_nxt[commit_areg] = commit_preg;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_aregs; i++) begin
                spec_map[i] <= preg_t'(i);  // Identity
                cmt_map[i]  <= preg_t'(i);
            end
        end else begin
            for (int i = 0; i < num_aregs; i++) begin
                cmt_map[i] <= cmt_nxt[i];
            end
            if (restore) begin
                for (int i = 0; i < num_aregs; i++) begin
                    spec_map[i] <= cmt_nxt[i];
                end
            end else if (ren_en && ren_dst_en) begin
                spec_map[dst_areg] <= new_preg;
            end
        end
    end

    // Reads see the table before this op's own update
    assign psrc1      = spec_map[src1_areg];
    assign psrc2      = spec_map[src2_areg];
    assign pdst_old   = spec_map[dst_areg];
    assign commit_old = cmt_map[commit_areg];

    always_comb begin
        used_vec = '0;
        for (int i = 0; i < num_aregs; i++) begin
            used_vec[cmt_map[i]] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/free_list.sv
`default_nettype none

module free_list (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc,
    input  logic              free_en,
    input  rename_pkg::preg_t free_preg,
    input  logic              scan_en,
    input  rename_pkg::preg_t scan_idx,
    input  logic              scan_free,
    input  logic              clear,
    output logic              empty,
    output rename_pkg::preg_t head
);
    import rename_pkg::*;

    preg_t ids [num_pregs];

    logic [flptr_w-1:0] wr_ptr;
    logic [flptr_w-1:0] rd_ptr;
    logic               push;
    preg_t              push_id;

    // Commit frees during a scan are dropped since the scan finds them
    assign push    = scan_en ? scan_free : free_en;
    assign push_id = scan_en ? scan_idx : free_preg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (alloc) rd_ptr <= rd_ptr + 1'b1;
            if (push)  wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !clear) begin
            ids[wr_ptr[flptr_w-2:0]] <= push_id;
        end
    end

    assign empty = (wr_ptr == rd_ptr);
    assign head  = ids[rd_ptr[flptr_w-2:0]];

endmodule

`default_nettype wire

// File: hw/prf_pend.sv
`default_nettype none

module prf_pend (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              set_pend,
    input  rename_pkg::preg_t set_preg,
    input  logic              wb_valid,
    input  rename_pkg::preg_t wb_preg,
    input  rename_pkg::data_t wb_data,
    input  rename_pkg::preg_t psrc1,
    input  rename_pkg::preg_t psrc2,
    input  logic              rd_en,
    input  rename_pkg::preg_t rd_preg,
    output logic              pend1,
    output logic              pend2,
    output rename_pkg::data_t rd_data
);
    import rename_pkg::*;

    data_t                regs [num_pregs];
    logic [num_pregs-1:0] pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
            for (int i = 0; i < num_pregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                regs[wb_preg] <= wb_data;
                pend[wb_preg] <= 1'b0;
            end
            if (set_pend) pend[set_preg] <= 1'b1;  // New owner wins
        end
    end

    // Same-cycle writeback counts as already done
    assign pend1 = pend[psrc1] && !(wb_valid && wb_preg == psrc1);
    assign pend2 = pend[psrc2] && !(wb_valid && wb_preg == psrc2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            if (wb_valid && wb_preg == rd_preg) begin
                rd_data <= wb_data;
            end else begin
                rd_data <= regs[rd_preg];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rename_top.sv
`default_nettype none

module rename_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic                uop_valid,
    input  rename_pkg::opkind_e dst_kind,
    input  rename_pkg::areg_t   dst_areg,
    input  rename_pkg::opkind_e src1_kind,
    input  rename_pkg::areg_t   src1_areg,
    input  rename_pkg::opkind_e src2_kind,
    input  rename_pkg::areg_t   src2_areg,
    input  logic                rob_credit_ret,
    input  logic                wb_valid,
    input  rename_pkg::preg_t   wb_preg,
    input  rename_pkg::data_t   wb_data,
    input  logic                commit_valid,
    input  rename_pkg::areg_t   commit_areg,
    input  rename_pkg::preg_t   commit_preg,
    input  logic                rd_en,
    input  rename_pkg::preg_t   rd_preg,
    output logic                dec_credit,
    output logic                busy,
    output logic                rn_valid,
    output rename_pkg::rob_id_t rn_robid,
    output rename_pkg::preg_t   rn_pdst,
    output rename_pkg::preg_t   rn_pdst_old,
    output rename_pkg::preg_t   rn_psrc1,
    output rename_pkg::preg_t   rn_psrc2,
    output logic                rn_psrc1_pend,
    output logic                rn_psrc2_pend,
    output rename_pkg::data_t   rd_data
);
    import rename_pkg::*;

    logic      q_empty;
    opkind_e   h_dst_kind;
    areg_t     h_dst_areg;
    opkind_e   h_src1_kind;
    areg_t     h_src1_areg;
    opkind_e   h_src2_kind;
    areg_t     h_src2_areg;
    logic      has_credit;
    rob_id_t   robid;
    rn_state_e state;
    preg_t     scan_idx;
    logic      scan_en;
    preg_t     psrc1;
    preg_t     psrc2;
    preg_t     pdst_old;
    preg_t     commit_old;
    logic      fl_empty;
    preg_t     fl_head;
    logic      pend1;
    logic      pend2;
    logic      dst_is_reg;
    logic      fire;
    logic      dst_alloc;

    logic [num_pregs-1:0] used_vec;

    assign dst_is_reg = (h_dst_kind == op_reg);
    assign fire = (state == st_run) && !q_empty && has_credit && !nuke &&
                  (!dst_is_reg || !fl_empty);
    assign dst_alloc  = fire && dst_is_reg;
    assign dec_credit = fire;  // One credit back per dequeue
    assign busy       = (state != st_run);

    uop_queue u_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (uop_valid),
        .dst_kind       (dst_kind),
        .dst_areg       (dst_areg),
        .src1_kind      (src1_kind),
        .src1_areg      (src1_areg),
        .src2_kind      (src2_kind),
        .src2_areg      (src2_areg),
        .pop            (fire),
        .nuke           (nuke),
        .empty          (q_empty),
        .head_dst_kind  (h_dst_kind),
        .head_dst_areg  (h_dst_areg),
        .head_src1_kind (h_src1_kind),
        .head_src1_areg (h_src1_areg),
        .head_src2_kind (h_src2_kind),
        .head_src2_areg (h_src2_areg)
    );

    rename_credit u_credit (
        .clk        (clk),
        .rst_n      (rst_n),
        .spend      (fire),
        .credit_ret (rob_credit_ret),
        .nuke       (nuke),
        .has_credit (has_credit),
        .robid      (robid)
    );

    rename_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .nuke     (nuke),
        .state    (state),
        .scan_idx (scan_idx),
        .scan_en  (scan_en)
    );

    rename_map u_map (
        .clk          (clk),
        .rst_n        (rst_n),
        .ren_en       (fire),
        .ren_dst_en   (dst_is_reg),
        .dst_areg     (h_dst_areg),
        .src1_areg    (h_src1_areg),
        .src2_areg    (h_src2_areg),
        .new_preg     (fl_head),
        .commit_valid (commit_valid),
        .commit_areg  (commit_areg),
        .commit_preg  (commit_preg),
        .restore      (nuke),
        .psrc1        (psrc1),
        .psrc2        (psrc2),
        .pdst_old     (pdst_old),
        .commit_old   (commit_old),
        .used_vec     (used_vec)
    );

    // Recovery refills with every register the committed map leaves out
    free_list u_free (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (dst_alloc),
        .free_en   (commit_valid),
        .free_preg (commit_old),
        .scan_en   (scan_en),
        .scan_idx  (scan_idx),
        .scan_free (!used_vec[scan_idx]),
        .clear     (nuke),
        .empty     (fl_empty),
        .head      (fl_head)
    );

    prf_pend u_prf (
        .clk      (clk),
        .rst_n    (rst_n),
        .set_pend (dst_alloc),
        .set_preg (fl_head),
        .wb_valid (wb_valid),
        .wb_preg  (wb_preg),
        .wb_data  (wb_data),
        .psrc1    (psrc1),
        .psrc2    (psrc2),
        .rd_en    (rd_en),
        .rd_preg  (rd_preg),
        .pend1    (pend1),
        .pend2    (pend2),
        .rd_data  (rd_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rn_valid <= 1'b0;
        else        rn_valid <= fire;  // Fire already drops on nuke
    end

    // Non-register operands report id 0 and no pending flag
    always_ff @(posedge clk) begin
        if (fire) begin
            rn_robid      <= robid;
            rn_pdst       <= dst_is_reg ? fl_head : '0;
            rn_pdst_old   <= dst_is_reg ? pdst_old : '0;
            rn_psrc1      <= (h_src1_kind == op_reg) ? psrc1 : '0;
            rn_psrc2      <= (h_src2_kind == op_reg) ? psrc2 : '0;
            rn_psrc1_pend <= (h_src1_kind == op_reg) && pend1;
            rn_psrc2_pend <= (h_src2_kind == op_reg) && pend2;
        end
    end

endmodule

`default_nettype wire

// File: bench/rename_asserts.sv
`default_nettype none

module rename_asserts (
    input logic clk,
    input logic rst_n,
    input logic nuke,
    input logic fire,
    input logic rob_credit_ret,
    input logic uop_valid,
    input logic dec_credit,
    input logic rn_valid
);
    import rename_pkg::*;

    int   rob_cnt;
    int   dec_out;  // Decode credits in flight
    logic bad_rob = 1'b0;
    logic bad_fire = 1'b0;
    logic bad_nuke = 1'b0;
    logic bad_dec = 1'b0;
    logic bad_any;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rob_cnt <= rob_credits;
            dec_out <= 0;
        end else if (nuke) begin
            rob_cnt <= rob_credits;
            dec_out <= 0;
        end else begin
            rob_cnt <= rob_cnt - int'(fire) + int'(rob_credit_ret);
            dec_out <= dec_out + int'(uop_valid) - int'(dec_credit);
        end
    end

    assign bad_any = bad_rob | bad_fire | bad_nuke | bad_dec;

    a_rob_range: assert property (@(posedge clk) disable iff (!rst_n)
        rob_cnt >= 0 && rob_cnt <= rob_credits)
        else begin
            $error("Reorder-buffer credit count out of range: %0d", rob_cnt);
            bad_rob = 1'b1;
        end

    a_fire_credit: assert property (@(posedge clk) disable iff (!rst_n)
        fire |-> rob_cnt > 0)
        else begin
            $error("Rename fired without a reorder-buffer credit");
            bad_fire = 1'b1;
        end

    a_nuke_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        nuke |=> !rn_valid)
        else begin
            $error("rn_valid high in the cycle after a nuke");
            bad_nuke = 1'b1;
        end

    a_dec_range: assert property (@(posedge clk) disable iff (!rst_n)
        dec_out >= 0 && dec_out <= queue_depth)
        else begin
            $error("Outstanding decode credits out of range: %0d", dec_out);
            bad_dec = 1'b1;
        end

endmodule

bind rename_top rename_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .nuke           (nuke),
    .fire           (fire),
    .rob_credit_ret (rob_credit_ret),
    .uop_valid      (uop_valid),
    .dec_credit     (dec_credit),
    .rn_valid       (rn_valid)
);

`default_nettype wire

// File: bench/rename_tb.sv
`default_nettype none

module rename_tb;
    import rename_pkg::*;

    localparam int timeout_cycles = 300;

    typedef struct packed {
        opkind_e dk;
        areg_t   da;
        opkind_e s1k;
        areg_t   s1a;
        opkind_e s2k;
        areg_t   s2a;
    } uop_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    nuke;
    logic    uop_valid;
    opkind_e dst_kind;
    areg_t   dst_areg;
    opkind_e src1_kind;
    areg_t   src1_areg;
    opkind_e src2_kind;
    areg_t   src2_areg;
    logic    rob_credit_ret;
    logic    wb_valid;
    preg_t   wb_preg;
    data_t   wb_data;
    logic    commit_valid;
    areg_t   commit_areg;
    preg_t   commit_preg;
    logic    rd_en;
    preg_t   rd_preg;
    logic    dec_credit;
    logic    busy;
    logic    rn_valid;
    rob_id_t rn_robid;
    preg_t   rn_pdst;
    preg_t   rn_pdst_old;
    preg_t   rn_psrc1;
    preg_t   rn_psrc2;
    logic    rn_psrc1_pend;
    logic    rn_psrc2_pend;
    data_t   rd_data;

    // Reference model state
    preg_t   spec_m [num_aregs];
    preg_t   cmt_m [num_aregs];
    preg_t   free_q [$];
    logic    pend_m [num_pregs];
    data_t   regs_m [num_pregs];
    uop_t    uop_q [$];  // Sent but not yet renamed
    rob_id_t exp_robid;
    int      dec_credits;
    int      renamed;
    logic    rd_chk;
    data_t   rd_exp;

    rename_top i_rename_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .nuke           (nuke),
        .uop_valid      (uop_valid),
        .dst_kind       (dst_kind),
        .dst_areg       (dst_areg),
        .src1_kind      (src1_kind),
        .src1_areg      (src1_areg),
        .src2_kind      (src2_kind),
        .src2_areg      (src2_areg),
        .rob_credit_ret (rob_credit_ret),
        .wb_valid       (wb_valid),
        .wb_preg        (wb_preg),
        .wb_data        (wb_data),
        .commit_valid   (commit_valid),
        .commit_areg    (commit_areg),
        .commit_preg    (commit_preg),
        .rd_en          (rd_en),
        .rd_preg        (rd_preg),
        .dec_credit     (dec_credit),
        .busy           (busy),
        .rn_valid       (rn_valid),
        .rn_robid       (rn_robid),
        .rn_pdst        (rn_pdst),
        .rn_pdst_old    (rn_pdst_old),
        .rn_psrc1       (rn_psrc1),
        .rn_psrc2       (rn_psrc2),
        .rn_psrc1_pend  (rn_psrc1_pend),
        .rn_psrc2_pend  (rn_psrc2_pend),
        .rd_data        (rd_data)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp)
            else stop_run($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, what, got, exp));
    endtask

    // Free registers in ascending order from what the committed map leaves out
    task automatic rebuild_free();
        logic held [num_pregs];
        for (int p = 0; p < num_pregs; p++) held[p] = 1'b0;
        for (int a = 0; a < num_aregs; a++) held[cmt_m[a]] = 1'b1;
        free_q.delete();
        for (int p = 0; p < num_pregs; p++) begin
            if (!held[p]) free_q.push_back(preg_t'(p));
        end
    endtask

    task automatic check_rename();
        uop_t  u;
        preg_t e_src1;
        preg_t e_src2;
        preg_t e_dst;
        preg_t e_old;
        logic  e_p1;
        logic  e_p2;
        assert (uop_q.size() > 0 && !busy)
            else stop_run("A rename result appeared that no pending micro-op explains");
        u = uop_q.pop_front();
        e_src1 = (u.s1k == op_reg) ? spec_m[u.s1a] : '0;  // Old mapping first
        e_src2 = (u.s2k == op_reg) ? spec_m[u.s2a] : '0;
        e_p1   = (u.s1k == op_reg) && pend_m[e_src1];
        e_p2   = (u.s2k == op_reg) && pend_m[e_src2];
        e_dst  = '0;
        e_old  = '0;
        if (u.dk == op_reg) begin
            assert (free_q.size() > 0) else stop_run("Model free list ran empty");
            e_dst = free_q.pop_front();
            e_old = spec_m[u.da];
            spec_m[u.da] = e_dst;
            pend_m[e_dst] = 1'b1;
        end
        expect_value("rn_robid", rn_robid, exp_robid);
        expect_value("rn_pdst", rn_pdst, e_dst);
        expect_value("rn_pdst_old", rn_pdst_old, e_old);
        expect_value("rn_psrc1", rn_psrc1, e_src1);
        expect_value("rn_psrc2", rn_psrc2, e_src2);
        expect_value("rn_psrc1_pend", rn_psrc1_pend, e_p1);
        expect_value("rn_psrc2_pend", rn_psrc2_pend, e_p2);
        exp_robid++;
        renamed++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (rn_valid) check_rename();
            if (dec_credit) dec_credits++;
            if (rd_chk) expect_value("rd_data", rd_data, rd_exp);
            if (i_rename_top.u_asserts.bad_any) stop_run("A bound assertion failed");
            rd_chk <= rd_en;
            rd_exp <= regs_m[rd_preg];
        end
    end

    task automatic send_uop(input opkind_e dk, input int da, input opkind_e s1k,
                            input int s1a, input opkind_e s2k, input int s2a);
        uop_t u;
        int   n;
        u = {dk, areg_t'(da), s1k, areg_t'(s1a), s2k, areg_t'(s2a)};
        n = 0;
        @(posedge clk);
        while (dec_credits == 0) begin
            n++;
            if (n > timeout_cycles) stop_run("Timeout waiting for a decode credit");
            @(posedge clk);
        end
        uop_valid <= 1'b1;
        dst_kind  <= u.dk;
        dst_areg  <= u.da;
        src1_kind <= u.s1k;
        src1_areg <= u.s1a;
        src2_kind <= u.s2k;
        src2_areg <= u.s2a;
        dec_credits--;
        uop_q.push_back(u);
        @(posedge clk);
        uop_valid <= 1'b0;
    endtask

    task automatic wait_renamed(input int target);
        int n;
        n = 0;
        while (renamed < target) begin
            n++;
            if (n > timeout_cycles) stop_run("Timeout waiting for rename results");
            @(posedge clk);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(posedge clk);
        while (busy) begin
            n++;
            if (n > timeout_cycles) stop_run("Timeout waiting for busy to drop");
            @(posedge clk);
        end
    endtask

    task automatic writeback(input int p);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_preg  <= preg_t'(p);
        wb_data  <= $urandom;
        @(posedge clk);  // Model follows what was just driven
        regs_m[p] = wb_data;
        pend_m[p] = 1'b0;
        wb_valid <= 1'b0;
    endtask

    task automatic read_reg(input int p);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_preg <= preg_t'(p);
        @(posedge clk);
        rd_en <= 1'b0;
        @(posedge clk);
    endtask

    task automatic ret_credits(input int count);
        repeat (count) begin
            @(posedge clk);
            rob_credit_ret <= 1'b1;
            @(posedge clk);
            rob_credit_ret <= 1'b0;
        end
    endtask

    task automatic commit(input int a, input int p, input logic with_nuke);
        @(posedge clk);
        commit_valid   <= 1'b1;
        commit_areg    <= areg_t'(a);
        commit_preg    <= preg_t'(p);
        nuke           <= with_nuke;
        rob_credit_ret <= 1'b0;
        if (!with_nuke) free_q.push_back(cmt_m[a]);
        cmt_m[a] = preg_t'(p);
        if (with_nuke) begin
            spec_m = cmt_m;
            rebuild_free();
            uop_q.delete();
            exp_robid   = '0;
            dec_credits = queue_depth;
        end
        @(posedge clk);
        commit_valid <= 1'b0;
        nuke         <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hea06af8a));
        rst_n = 1'b0;
        nuke = 1'b0;
        uop_valid = 1'b0;
        rob_credit_ret = 1'b0;
        dst_kind = op_none;
        src1_kind = op_none;
        src2_kind = op_none;
        dst_areg = '0;
        src1_areg = '0;
        src2_areg = '0;
        wb_valid = 1'b0;
        wb_preg = '0;
        wb_data = '0;
        commit_valid = 1'b0;
        commit_areg = '0;
        commit_preg = '0;
        rd_en = 1'b0;
        rd_preg = '0;
        for (int a = 0; a < num_aregs; a++) begin
            spec_m[a] = preg_t'(a);
            cmt_m[a]  = preg_t'(a);
        end
        for (int p = 0; p < num_pregs; p++) begin
            pend_m[p] = 1'b0;
            regs_m[p] = '0;
        end
        rebuild_free();
        exp_robid = '0;
        dec_credits = queue_depth;
        renamed = 0;
        rd_chk = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait_ready();

        send_uop(op_none, 0, op_reg, 3, op_reg, 9);
        wait_renamed(1);
        send_uop(op_reg, 2, op_reg, 2, op_imm, 0);
        send_uop(op_reg, 2, op_reg, 2, op_none, 0);
        send_uop(op_reg, 5, op_reg, 2, op_reg, 5);
        wait_renamed(4);
        writeback(17);
        send_uop(op_none, 0, op_reg, 2, op_reg, 5);
        wait_renamed(5);
        writeback(18);
        read_reg(17);
        read_reg(18);
        read_reg(3);
        ret_credits(5);

        // Twelve micro-ops against eight credits
        for (int k = 0; k < 12; k++) send_uop(op_none, 0, op_imm, 0, op_reg, k);
        wait_renamed(13);
        repeat (12) @(posedge clk);
        assert (renamed == 13) else stop_run("More renames than reorder-buffer credits");
        ret_credits(2);
        wait_renamed(15);

        commit(2, 16, 1'b0);
        commit(5, 18, 1'b0);
        @(posedge clk);
        rob_credit_ret <= 1'b1;  // Queued op would fire in the nuke cycle
        commit(2, 17, 1'b1);  // Lands with the nuke
        send_uop(op_reg, 2, op_reg, 2, op_reg, 5);
        send_uop(op_reg, 9, op_reg, 2, op_reg, 9);
        wait_ready();
        wait_renamed(17);
        read_reg(18);

        repeat (4) @(posedge clk);
        if (uop_q.size() == 0 && renamed == 17) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_run("Micro-ops were left without a rename result");
        end
    end

endmodule

`default_nettype wire

// File: project.f
hw/rename_pkg.sv
hw/uop_queue.sv
hw/rename_credit.sv
hw/rename_ctrl.sv
hw/rename_map.sv
hw/free_list.sv
hw/prf_pend.sv
hw/rename_top.sv
bench/rename_asserts.sv
bench/rename_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rename_tb \
    -f project.f -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rename_sim +verilator+error+limit+100 > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Something failed" "$log"; then
    echo "Simulation reported a failure, see $log"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0
